// ==== all.f ====
hw/cache_pkg.sv
hw/cache_set_array.sv
hw/wb_line_mover.sv
hw/wb_ram.sv
hw/cache_ctrl.sv
hw/cache_top.sv
dv/cache_tb.sv

// ==== Bender.yml ====
package:
  name: cache

sources:
  # Design, package first
  - files:
      - hw/cache_pkg.sv
      - hw/cache_set_array.sv
      - hw/wb_line_mover.sv
      - hw/wb_ram.sv
      - hw/cache_ctrl.sv
      - hw/cache_top.sv

  # Testbench
  - target: simulation
    files:
      - dv/cache_tb.sv

// ==== dv/cache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_tb;

	localparam int NUM_OPS = 300;
	localparam int SEED = 91;
	localparam int READY_TIMEOUT = 20000;
	localparam int MEM_ADDR_W = 12;
	localparam int SETS = 2 ** cache_pkg::INDEX_W;

	logic clk = 1'b0;
	logic reset;
	logic req_valid;
	cache_pkg::cache_req_t req;
	logic ready;
	cache_pkg::cache_rsp_t rsp;

	// Expected responses in request order
	cache_pkg::cache_rsp_t exp_q[$];
	cache_pkg::cache_rsp_t exp_rsp;
	int n_sent = 0;
	int n_checked = 0;

	// Reference state, memory plus two ways per set
	logic [cache_pkg::DATA_W-1:0] ref_mem [2**MEM_ADDR_W];
	cache_pkg::tag_entry_t ref_tag [SETS][cache_pkg::NUM_WAYS];
	cache_pkg::line_t ref_data [SETS][cache_pkg::NUM_WAYS];
	logic ref_lru [SETS];

	cache_top #(.WAIT_STATES(2), .MEM_ADDR_W(MEM_ADDR_W)) i_dut (
		.clk(clk), .reset(reset), .req_valid(req_valid), .req(req),
		.ready(ready), .rsp(rsp)
	);

	// 8 ns period
	always #4 clk = ~clk;

	// --------------------------------------------------
	// Error exits
	// --------------------------------------------------
	task automatic abort_run(input string line);
		$display("%s", line);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	task automatic check_rsp(input cache_pkg::cache_rsp_t got, input cache_pkg::cache_rsp_t exp);
		if (got !== exp) begin
			abort_run($sformatf("Fail at %0t: rsp rdata %h hit %b, expected rdata %h hit %b",
				$time, got.rdata, got.hit, exp.rdata, exp.hit));
		end
	endtask

	// Ready is stable around the falling edge
	task automatic check_ready_seen();
		for (int i = 0; i < READY_TIMEOUT; i++) begin
			@(negedge clk);
			if (ready) return;
		end
		abort_run($sformatf("Timeout at %0t: no ready within %0d cycles", $time, READY_TIMEOUT));
	endtask

	// --------------------------------------------------
	// Reference model
	// --------------------------------------------------
	function automatic logic [cache_pkg::ADDR_W-1:0] line_base(
		input logic [cache_pkg::TAG_W-1:0] tag,
		input logic [cache_pkg::INDEX_W-1:0] idx
	);
		return {tag, idx, {cache_pkg::OFFSET_W{1'b0}}};
	endfunction

	function automatic cache_pkg::line_t fetch_line(input logic [cache_pkg::ADDR_W-1:0] base);
		cache_pkg::line_t ln;
		for (int i = 0; i < cache_pkg::LINE_WORDS; i++) begin
			ln[i] = ref_mem[base[MEM_ADDR_W-1:0] + i];
		end
		return ln;
	endfunction

	function automatic void store_line(
		input logic [cache_pkg::ADDR_W-1:0] base,
		input cache_pkg::line_t ln
	);
		for (int i = 0; i < cache_pkg::LINE_WORDS; i++) begin
			ref_mem[base[MEM_ADDR_W-1:0] + i] = ln[i];
		end
	endfunction

	function automatic cache_pkg::cache_rsp_t ref_access(input cache_pkg::cache_req_t r);
		cache_pkg::cache_rsp_t res;
		cache_pkg::line_t ln;
		logic [cache_pkg::TAG_W-1:0] tag;
		logic [cache_pkg::INDEX_W-1:0] idx;
		logic [cache_pkg::OFFSET_W-1:0] off;
		int way;
		int vic;
		res = '0;
		// Flush writes back dirty lines and drops everything, LRU kept
		if (r.flush) begin
			for (int s = 0; s < SETS; s++) begin
				for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
					if (ref_tag[s][w].valid && ref_tag[s][w].dirty) begin
						store_line(line_base(ref_tag[s][w].tag, cache_pkg::INDEX_W'(s)),
							ref_data[s][w]);
					end
					ref_tag[s][w] = '0;
				end
			end
			return res;
		end
		{tag, idx, off} = r.addr;
		way = -1;
		for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
			if (ref_tag[idx][w].valid && ref_tag[idx][w].tag == tag) way = w;
		end
		// Hit
		if (way >= 0) begin
			res.hit = 1'b1;
			if (r.write) begin
				ref_data[idx][way][off] = r.wdata;
				ref_tag[idx][way].dirty = 1'b1;
			end else begin
				res.rdata = ref_data[idx][way][off];
			end
			ref_lru[idx] = (way == 0);
			return res;
		end
		// Miss, empty way 0 then empty way 1 then LRU
		if (!ref_tag[idx][0].valid) vic = 0;
		else if (!ref_tag[idx][1].valid) vic = 1;
		else vic = ref_lru[idx];
		if (ref_tag[idx][vic].valid && ref_tag[idx][vic].dirty) begin
			store_line(line_base(ref_tag[idx][vic].tag, idx), ref_data[idx][vic]);
		end
		ln = fetch_line(line_base(tag, idx));
		if (r.write) ln[off] = r.wdata;
		else res.rdata = ln[off];
		ref_tag[idx][vic] = '{valid: 1'b1, dirty: r.write, tag: tag};
		ref_data[idx][vic] = ln;
		ref_lru[idx] = (vic == 0);
		return res;
	endfunction

	// Matches the init walk, memory starts zero-filled
	task automatic clear_model();
		foreach (ref_mem[i]) ref_mem[i] = '0;
		for (int s = 0; s < SETS; s++) begin
			ref_lru[s] = 1'b0;
			for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
				ref_tag[s][w] = '0;
				ref_data[s][w] = '0;
			end
		end
	endtask

	// --------------------------------------------------
	// Stimulus
	// --------------------------------------------------
	function automatic cache_pkg::cache_req_t read_req(input logic [11:0] a);
		return '{addr: cache_pkg::ADDR_W'(a), wdata: '0, write: 1'b0, flush: 1'b0};
	endfunction

	function automatic cache_pkg::cache_req_t write_req(input logic [11:0] a, input logic [31:0] d);
		return '{addr: cache_pkg::ADDR_W'(a), wdata: d, write: 1'b1, flush: 1'b0};
	endfunction

	function automatic cache_pkg::cache_req_t flush_req();
		return '{addr: '0, wdata: '0, write: 1'b0, flush: 1'b1};
	endfunction

	// want_hit below zero means no directed hit expectation
	task automatic run_op(input cache_pkg::cache_req_t r, input int want_hit);
		cache_pkg::cache_rsp_t exp;
		exp = ref_access(r);
		if (want_hit >= 0 && int'(exp.hit) != want_hit) begin
			abort_run($sformatf("Model predicts hit %b for address %h, scenario needs %0d",
				exp.hit, r.addr, want_hit));
		end
		exp_q.push_back(exp);
		n_sent++;
		@(posedge clk);
		#1;
		req = r;
		req_valid = 1'b1;
		check_ready_seen();
		@(posedge clk);
		#1;
		req_valid = 1'b0;
	endtask

	task automatic run_random_mix();
		logic [3:0] rnd_tag;
		logic [5:0] rnd_idx;
		logic [1:0] rnd_off;
		int sel;
		for (int n = 0; n < NUM_OPS; n++) begin
			rnd_tag = 4'($urandom_range(0, 15));
			// Sets 4 to 7, overlaps the eviction set
			rnd_idx = 6'(4 + $urandom_range(0, 3));
			rnd_off = 2'($urandom_range(0, 3));
			sel = $urandom_range(0, 39);
			if (sel == 0) run_op(flush_req(), 0);
			else if (sel < 20) run_op(write_req({rnd_tag, rnd_idx, rnd_off}, $urandom()), -1);
			else run_op(read_req({rnd_tag, rnd_idx, rnd_off}), -1);
		end
	endtask

	// --------------------------------------------------
	// Response compare
	// --------------------------------------------------
	always @(negedge clk) begin
		if (!reset && ready) begin
			if (exp_q.size() == 0) begin
				abort_run("Ready raised with no request outstanding");
			end else begin
				exp_rsp = exp_q.pop_front();
				check_rsp(rsp, exp_rsp);
				n_checked++;
			end
		end
	end

	initial begin
		void'($urandom(SEED));
		reset = 1'b1;
		req_valid = 1'b0;
		req = '0;
		clear_model();
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;

		// Cold reads then hits in the same line
		run_op(read_req(12'h040), 0);
		run_op(read_req(12'h040), 1);
		run_op(read_req(12'h043), 1);

		// Write hit, write miss, read back
		run_op(write_req(12'h041, 32'hcafe_0001), 1);
		run_op(read_req(12'h041), 1);
		run_op(write_req(12'h3a5, 32'h1234_5678), 0);
		run_op(read_req(12'h3a5), 1);

		// Three tags on set 6
		run_op(write_req(12'h018, 32'haaaa_0018), 0);
		run_op(write_req(12'h218, 32'hbbbb_0218), 0);
		run_op(read_req(12'h018), 1);
		// Evicts dirty 218
		run_op(read_req(12'h118), 0);
		// 218 comes back from memory, 018 goes out
		run_op(read_req(12'h218), 0);
		run_op(read_req(12'h018), 0);

		// Flush, then everything misses once
		run_op(flush_req(), 0);
		run_op(read_req(12'h041), 0);
		run_op(read_req(12'h040), 1);
		run_op(read_req(12'h3a5), 0);
		run_op(read_req(12'h018), 0);
		run_op(read_req(12'h218), 0);
		run_op(read_req(12'h118), 0);

		run_random_mix();

		@(negedge clk);
		if (exp_q.size() != 0 || n_checked != n_sent) begin
			abort_run($sformatf("Response count mismatch: %0d sent, %0d checked",
				n_sent, n_checked));
		end else begin
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== hw/cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_top #(
	parameter int WAIT_STATES = 2,
	parameter int MEM_ADDR_W = 12
) (
	input  logic clk,
	input  logic reset,
	input  logic req_valid,
	input  cache_pkg::cache_req_t req,
	output logic ready,
	output cache_pkg::cache_rsp_t rsp
);

	localparam int SETS = 2 ** cache_pkg::INDEX_W;

	// --------------------------------------------------
	// Controller to arrays
	// --------------------------------------------------
	logic [cache_pkg::INDEX_W-1:0] tag_rd_index, data_rd_index, wr_index;
	cache_pkg::tag_entry_t [cache_pkg::NUM_WAYS-1:0] tag_rd_data;
	cache_pkg::line_t [cache_pkg::NUM_WAYS-1:0] data_rd_data;
	logic [cache_pkg::NUM_WAYS-1:0] tag_wr_en, data_wr_en;
	cache_pkg::tag_entry_t tag_wr_data;
	cache_pkg::line_t data_wr_data;

	// Controller to mover and mover to RAM
	logic mv_start, mv_done;
	cache_pkg::line_xfer_t mv_xfer;
	cache_pkg::line_t mv_line;
	cache_pkg::wb_req_t wb_req;
	cache_pkg::wb_rsp_t wb_rsp;

	cache_ctrl i_ctrl (
		.clk(clk), .reset(reset),
		.req_valid(req_valid), .req(req), .ready(ready), .rsp(rsp),
		.tag_rd_index(tag_rd_index), .data_rd_index(data_rd_index),
		.tag_rd_data(tag_rd_data), .data_rd_data(data_rd_data),
		.tag_wr_en(tag_wr_en), .data_wr_en(data_wr_en), .wr_index(wr_index),
		.tag_wr_data(tag_wr_data), .data_wr_data(data_wr_data),
		.mv_start(mv_start), .mv_xfer(mv_xfer), .mv_done(mv_done), .mv_line(mv_line)
	);

	// Tag and data storage per way
	for (genvar w = 0; w < cache_pkg::NUM_WAYS; w++) begin : g_way
		cache_set_array #(.DEPTH(SETS), .entry_t(cache_pkg::tag_entry_t)) i_tag (
			.clk(clk), .rd_index(tag_rd_index), .rd_data(tag_rd_data[w]),
			.wr_en(tag_wr_en[w]), .wr_index(wr_index), .wr_data(tag_wr_data)
		);
		cache_set_array #(.DEPTH(SETS), .entry_t(cache_pkg::line_t)) i_data (
			.clk(clk), .rd_index(data_rd_index), .rd_data(data_rd_data[w]),
			.wr_en(data_wr_en[w]), .wr_index(wr_index), .wr_data(data_wr_data)
		);
	end

	wb_line_mover i_mover (
		.clk(clk), .reset(reset), .start(mv_start), .xfer(mv_xfer),
		.done(mv_done), .line(mv_line), .wb_req(wb_req), .wb_rsp(wb_rsp)
	);

	wb_ram #(.WAIT_STATES(WAIT_STATES), .MEM_ADDR_W(MEM_ADDR_W)) i_ram (
		.clk(clk), .reset(reset), .wb_req(wb_req), .wb_rsp(wb_rsp)
	);

endmodule

`default_nettype wire

// ==== hw/cache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
	input  logic clk,
	input  logic reset,
	input  logic req_valid,
	input  cache_pkg::cache_req_t req,
	output logic ready,
	output cache_pkg::cache_rsp_t rsp,
	output logic [cache_pkg::INDEX_W-1:0] tag_rd_index,
	output logic [cache_pkg::INDEX_W-1:0] data_rd_index,
	input  cache_pkg::tag_entry_t [cache_pkg::NUM_WAYS-1:0] tag_rd_data,
	input  cache_pkg::line_t [cache_pkg::NUM_WAYS-1:0] data_rd_data,
	output logic [cache_pkg::NUM_WAYS-1:0] tag_wr_en,
	output logic [cache_pkg::NUM_WAYS-1:0] data_wr_en,
	output logic [cache_pkg::INDEX_W-1:0] wr_index,
	output cache_pkg::tag_entry_t tag_wr_data,
	output cache_pkg::line_t data_wr_data,
	output logic mv_start,
	output cache_pkg::line_xfer_t mv_xfer,
	input  logic mv_done,
	input  cache_pkg::line_t mv_line
);

	typedef enum logic [2:0] {
		ST_INIT, ST_IDLE, ST_LOOKUP, ST_COMPARE,
		ST_WRITEBACK, ST_REFILL, ST_RESPOND, ST_FLUSH
	} state_t;

	state_t state, state_nx;
	cache_pkg::cache_req_t req_q;
	cache_pkg::cache_rsp_t rsp_nx;
	// One bit per set naming the way to evict next
	logic lru [2**cache_pkg::INDEX_W];
	logic [cache_pkg::INDEX_W-1:0] set_cnt;
	logic way_cnt, fl_phase, flushing, fl_last;
	logic victim, victim_q, hit_way;
	logic [cache_pkg::NUM_WAYS-1:0] hit_w;
	logic [cache_pkg::TAG_W-1:0] req_tag;
	logic [cache_pkg::INDEX_W-1:0] req_idx;
	logic [cache_pkg::OFFSET_W-1:0] req_off;
	cache_pkg::line_t hit_line, fill_line;

	assign {req_tag, req_idx, req_off} = req_q.addr;
	assign tag_rd_index = (flushing || state == ST_INIT) ? set_cnt : req_idx;
	assign data_rd_index = tag_rd_index;
	assign ready = (state == ST_RESPOND);
	assign fl_last = &{set_cnt, way_cnt};

	// --------------------------------------------------
	// Tag match and victim choice
	// --------------------------------------------------
	always_comb begin
		for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
			hit_w[w] = tag_rd_data[w].valid && (tag_rd_data[w].tag == req_tag);
		end
		hit_way = hit_w[1];
		// Empty way 0 first then empty way 1 then LRU
		if (!tag_rd_data[0].valid) victim = 1'b0;
		else if (!tag_rd_data[1].valid) victim = 1'b1;
		else victim = lru[req_idx];
		// Store word merged into hit line or refilled line
		hit_line = data_rd_data[hit_way];
		hit_line[req_off] = req_q.wdata;
		fill_line = mv_line;
		fill_line[req_off] = req_q.wdata;
	end

	// --------------------------------------------------
	// Next state and array controls
	// --------------------------------------------------
	always_comb begin
		state_nx = state;
		rsp_nx = rsp;
		tag_wr_en = '0;
		data_wr_en = '0;
		wr_index = req_idx;
		tag_wr_data = '{valid: 1'b1, dirty: req_q.write, tag: req_tag};
		data_wr_data = req_q.write ? fill_line : mv_line;
		mv_start = 1'b0;
		// Refill of the requested line unless overridden
		mv_xfer.base = {req_tag, req_idx, {cache_pkg::OFFSET_W{1'b0}}};
		mv_xfer.write = 1'b0;
		mv_xfer.line = data_rd_data[victim];
		case (state)
			ST_INIT: begin
				tag_wr_en = '1;
				wr_index = set_cnt;
				tag_wr_data = '0;
				if (set_cnt == '1) state_nx = ST_IDLE;
			end
			ST_IDLE: if (req_valid) begin
				state_nx = req.flush ? ST_FLUSH : ST_LOOKUP;
				if (req.flush) rsp_nx = '0;
			end
			ST_LOOKUP: state_nx = ST_COMPARE;
			ST_COMPARE: begin
				if (|hit_w) begin
					state_nx = ST_RESPOND;
					rsp_nx.hit = 1'b1;
					rsp_nx.rdata = req_q.write ? '0 : data_rd_data[hit_way][req_off];
					tag_wr_en[hit_way] = req_q.write;
					data_wr_en[hit_way] = req_q.write;
					data_wr_data = hit_line;
				end else begin
					mv_start = 1'b1;
					state_nx = ST_REFILL;
					// Dirty victim goes out before the refill
					if (tag_rd_data[victim].valid && tag_rd_data[victim].dirty) begin
						mv_xfer.base = {tag_rd_data[victim].tag, req_idx,
							{cache_pkg::OFFSET_W{1'b0}}};
						mv_xfer.write = 1'b1;
						state_nx = ST_WRITEBACK;
					end
				end
			end
			ST_WRITEBACK: if (mv_done) begin
				if (!flushing) begin
					mv_start = 1'b1;
					state_nx = ST_REFILL;
				end else begin
					state_nx = fl_last ? ST_RESPOND : ST_FLUSH;
				end
			end
			ST_REFILL: if (mv_done) begin
				tag_wr_en[victim_q] = 1'b1;
				data_wr_en[victim_q] = 1'b1;
				rsp_nx.hit = 1'b0;
				rsp_nx.rdata = req_q.write ? '0 : mv_line[req_off];
				state_nx = ST_RESPOND;
			end
			ST_RESPOND: state_nx = ST_IDLE;
			ST_FLUSH: if (fl_phase) begin
				// Invalidate this way and write it back if dirty
				wr_index = set_cnt;
				tag_wr_en[way_cnt] = 1'b1;
				tag_wr_data = '0;
				if (tag_rd_data[way_cnt].valid && tag_rd_data[way_cnt].dirty) begin
					mv_start = 1'b1;
					mv_xfer.base = {tag_rd_data[way_cnt].tag, set_cnt,
						{cache_pkg::OFFSET_W{1'b0}}};
					mv_xfer.write = 1'b1;
					mv_xfer.line = data_rd_data[way_cnt];
					state_nx = ST_WRITEBACK;
				end else if (fl_last) begin
					state_nx = ST_RESPOND;
				end
			end
			default: state_nx = ST_INIT;
		endcase
	end

	// --------------------------------------------------
	// Control registers
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_INIT;
			set_cnt <= '0;
			way_cnt <= 1'b0;
			fl_phase <= 1'b0;
			flushing <= 1'b0;
		end else begin
			state <= state_nx;
			case (state)
				ST_INIT: set_cnt <= set_cnt + 1'b1;
				ST_IDLE: if (req_valid) begin
					flushing <= req.flush;
					set_cnt <= '0;
					way_cnt <= 1'b0;
					fl_phase <= 1'b0;
				end
				// Phase 0 reads the set and phase 1 acts on it
				ST_FLUSH: if (!fl_phase) begin
					fl_phase <= 1'b1;
				end else if (!mv_start) begin
					{set_cnt, way_cnt} <= {set_cnt, way_cnt} + 1'b1;
					fl_phase <= 1'b0;
				end
				ST_WRITEBACK: if (mv_done && flushing) begin
					{set_cnt, way_cnt} <= {set_cnt, way_cnt} + 1'b1;
					fl_phase <= 1'b0;
				end
				ST_RESPOND: flushing <= 1'b0;
				default: ;
			endcase
		end
	end

	// Request hold, response and LRU table
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && req_valid) req_q <= req;
		if (state == ST_COMPARE) victim_q <= victim;
		rsp <= rsp_nx;
		if (state == ST_INIT) lru[set_cnt] <= 1'b0;
		// Point at the other way after every hit or fill
		if (state == ST_COMPARE && |hit_w) lru[req_idx] <= !hit_way;
		if (state == ST_REFILL && mv_done) lru[req_idx] <= !victim_q;
	end

	a_ready_pulse: assert property (
		@(posedge clk) disable iff (reset) ready |=> !ready
	) else $error("ready held for two cycles");

endmodule

`default_nettype wire

// ==== hw/wb_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_ram #(
	parameter int WAIT_STATES = 2,
	parameter int MEM_ADDR_W = 12
) (
	input  logic clk,
	input  logic reset,
	input  cache_pkg::wb_req_t wb_req,
	output cache_pkg::wb_rsp_t wb_rsp
);

	localparam int CNT_W = $clog2(WAIT_STATES + 2);

	// Zero filled at start
	logic [cache_pkg::DATA_W-1:0] mem [2**MEM_ADDR_W] = '{default: '0};
	logic [CNT_W-1:0] wait_cnt;
	logic [MEM_ADDR_W-1:0] word_adr;
	logic ack;
	// Read word registered on the ack edge
	logic [cache_pkg::DATA_W-1:0] dat_r;

	// Upper address bits alias
	assign word_adr = wb_req.adr[MEM_ADDR_W-1:0];
	assign wb_rsp.ack = ack;
	assign wb_rsp.dat_r = dat_r;

	// --------------------------------------------------
	// Wait states then a single ack pulse
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			ack <= 1'b0;
			wait_cnt <= '0;
		end else begin
			ack <= 1'b0;
			// No recount while the ack is out
			if (wb_req.cyc && wb_req.stb && !ack) begin
				if (wait_cnt == CNT_W'(WAIT_STATES)) begin
					ack <= 1'b1;
					wait_cnt <= '0;
				end else begin
					wait_cnt <= wait_cnt + 1'b1;
				end
			end
		end
	end

	// Data moves on the ack edge
	always_ff @(posedge clk) begin
		if (wb_req.cyc && wb_req.stb && !ack && wait_cnt == CNT_W'(WAIT_STATES)) begin
			if (wb_req.we) begin
				mem[word_adr] <= wb_req.dat_w;
			end
			dat_r <= mem[word_adr];
		end
	end

endmodule

`default_nettype wire

// ==== hw/wb_line_mover.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_line_mover (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  cache_pkg::line_xfer_t xfer,
	output logic done,
	output cache_pkg::line_t line,
	output cache_pkg::wb_req_t wb_req,
	input  cache_pkg::wb_rsp_t wb_rsp
);

	// Cycle stays up for the whole line
	logic busy;
	logic stb;
	logic write_q;
	logic [cache_pkg::OFFSET_W-1:0] word_cnt;
	logic [cache_pkg::ADDR_W-cache_pkg::OFFSET_W-1:0] line_adr;
	// Write data leaves from word 0 and read data enters at the top
	cache_pkg::line_t line_buf;

	assign wb_req.cyc = busy;
	assign wb_req.stb = stb;
	assign wb_req.we = write_q;
	assign wb_req.adr = {line_adr, word_cnt};
	assign wb_req.dat_w = line_buf[0];
	assign line = line_buf;

	// --------------------------------------------------
	// Bus sequencing
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			stb <= 1'b0;
			done <= 1'b0;
			word_cnt <= '0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				stb <= 1'b1;
				word_cnt <= '0;
			end else if (stb && wb_rsp.ack) begin
				// Strobe low for one cycle between words
				stb <= 1'b0;
				word_cnt <= word_cnt + 1'b1;
				if (word_cnt == '1) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end else if (busy && !stb) begin
				stb <= 1'b1;
			end
		end
	end

	// Line buffer shifts one word per ack
	always_ff @(posedge clk) begin
		if (start) begin
			line_buf <= xfer.line;
			line_adr <= xfer.base[cache_pkg::ADDR_W-1:cache_pkg::OFFSET_W];
			write_q <= xfer.write;
		end else if (stb && wb_rsp.ack) begin
			line_buf <= {wb_rsp.dat_r, line_buf[cache_pkg::LINE_WORDS-1:1]};
		end
	end

	// --------------------------------------------------
	// Checks
	// --------------------------------------------------
	a_stb_in_cyc: assert property (
		@(posedge clk) disable iff (reset) stb |-> busy
	) else $error("stb without cyc");

	a_start_idle: assert property (
		@(posedge clk) disable iff (reset) start |-> !busy
	) else $error("line transfer started while busy");

endmodule

`default_nettype wire

// ==== hw/cache_set_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_set_array #(
	parameter int DEPTH = 64,
	parameter type entry_t = logic
) (
	input  logic clk,
	input  logic [cache_pkg::INDEX_W-1:0] rd_index,
	output entry_t rd_data,
	input  logic wr_en,
	input  logic [cache_pkg::INDEX_W-1:0] wr_index,
	input  entry_t wr_data
);

	// One entry per set
	entry_t mem [DEPTH];

	// --------------------------------------------------
	// Storage
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_index] <= wr_data;
		end
		// Registered read returns the old entry on a same-set write
		rd_data <= mem[rd_index];
	end

	// --------------------------------------------------
	// Checks
	// --------------------------------------------------
	// Index width may exceed the set count
	a_rd_index_range: assert property (
		@(posedge clk) !$isunknown(rd_index) |-> (rd_index < DEPTH)
	) else $error("set array read index out of range");

	a_wr_index_range: assert property (
		@(posedge clk) wr_en |-> (wr_index < DEPTH)
	) else $error("set array write index out of range");

endmodule

`default_nettype wire

// ==== hw/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

	// --------------------------------------------------
	// Address split and cache geometry
	// --------------------------------------------------
	localparam int ADDR_W = 28;
	localparam int DATA_W = 32;
	localparam int OFFSET_W = 2;
	localparam int INDEX_W = 6;
	localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;
	// Two ways only, the LRU state is a single bit per set
	localparam int NUM_WAYS = 2;
	localparam int LINE_WORDS = 2 ** OFFSET_W;

	// Whole line, word 0 in the low bits
	typedef logic [LINE_WORDS-1:0][DATA_W-1:0] line_t;

	typedef struct packed {
		logic valid;
		logic dirty;
		logic [TAG_W-1:0] tag;
	} tag_entry_t;

	// --------------------------------------------------
	// Client port
	// --------------------------------------------------
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic write;
		logic flush;
	} cache_req_t;

	typedef struct packed {
		logic [DATA_W-1:0] rdata;
		logic hit;
	} cache_rsp_t;

	// --------------------------------------------------
	// Wishbone classic and line transfer
	// --------------------------------------------------
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [ADDR_W-1:0] adr;
		logic [DATA_W-1:0] dat_w;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		logic [DATA_W-1:0] dat_r;
	} wb_rsp_t;

	// Base has zero offset bits
	typedef struct packed {
		logic [ADDR_W-1:0] base;
		logic write;
		line_t line;
	} line_xfer_t;

endpackage

`default_nettype wire
